// ==== cnn_core.f ====
+incdir+verification
hw/cnn_pkg.sv
hw/conv_window_gen.sv
hw/conv_param_rom.sv
hw/cnn_acc_ci.sv
hw/conv_bias_relu.sv
hw/cnn_core.sv
verification/cnn_core_tb.sv

// ==== hw/cnn_acc_ci.sv ====
//==================================================
// two-stage mac of one output channel: registered
// products, then registered sum over CI*K*K taps
//==================================================
`timescale 1ns/1ns

module cnn_acc_ci import cnn_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    i_in_valid,
    input  pixel_t  i_window [CI][K][K],
    input  weight_t i_weight [CI][K][K],
    output logic    o_acc_valid,
    output acc_t    o_acc
);

    // full product of pixel and weight
    localparam int PBW = IBW + W_BW;

    //==================================================
    // stage 1 products
    //==================================================
    logic signed [PBW-1:0] r_prod [CI][K][K];

    // pipeline advances every cycle, valid tags the data
    always_ff @(posedge clk) begin
        for (int ci = 0; ci < CI; ci++) begin
            for (int ky = 0; ky < K; ky++) begin
                for (int kx = 0; kx < K; kx++) begin
                    r_prod[ci][ky][kx] <= i_window[ci][ky][kx] * i_weight[ci][ky][kx];
                end
            end
        end
    end

    //==================================================
    // stage 2 sum
    //==================================================
    acc_t acc_sum;

    // signed sum, products sign-extended into acc width
    always_comb begin
        acc_sum = '0;
        for (int ci = 0; ci < CI; ci++) begin
            for (int ky = 0; ky < K; ky++) begin
                for (int kx = 0; kx < K; kx++) begin
                    acc_sum = acc_sum + r_prod[ci][ky][kx];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        o_acc <= acc_sum;
    end

    //==================================================
    // valid pipe
    //==================================================
    logic [1:0] r_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[0], i_in_valid};
        end
    end

    assign o_acc_valid = r_valid[1];

    // fixed two cycle latency
    a_acc_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_acc_valid |-> $past(i_in_valid, 2)
    ) else $error("accumulator valid not two cycles after window valid");

endmodule

// ==== hw/cnn_core.sv ====
//==================================================
// conv layer top: window generator, one rom and mac
// per output channel, then shared bias/relu stage
//==================================================
`timescale 1ns/1ns

module cnn_core import cnn_pkg::*; #(
    parameter int IMG_X = 6,
    parameter int IMG_Y = 6
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  logic [CI*IBW-1:0] i_in_fmap,
    output logic              o_ot_valid,
    output logic [CO*OBW-1:0] o_ot_fmap
);

    //==================================================
    // window generator
    //==================================================
    logic   w_win_valid;
    pixel_t w_window [CI][K][K];

    conv_window_gen #(
        .IMG_X (IMG_X),
        .IMG_Y (IMG_Y)
    ) u_window_gen (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_fmap   (i_in_fmap),
        .o_win_valid (w_win_valid),
        .o_window    (w_window)
    );

    //==================================================
    // per output channel rom and mac
    //==================================================
    logic  [CO-1:0] w_acc_valid;
    acc_t  [CO-1:0] w_acc;
    bias_t [CO-1:0] w_bias;

    for (genvar co = 0; co < CO; co++) begin : g_co
        weight_t w_weight [CI][K][K];

        conv_param_rom #(
            .CHANNEL_ID (co)
        ) u_rom (
            .o_weight (w_weight),
            .o_bias   (w_bias[co])
        );

        // same window and strobe into every channel
        cnn_acc_ci u_acc_ci (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_in_valid  (w_win_valid),
            .i_window    (w_window),
            .i_weight    (w_weight),
            .o_acc_valid (w_acc_valid[co]),
            .o_acc       (w_acc[co])
        );
    end

    //==================================================
    // bias and relu
    //==================================================
    // channel 0 strobe stands for all of them
    conv_bias_relu u_bias_relu (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_acc_valid (w_acc_valid[0]),
        .i_acc       (w_acc),
        .i_bias      (w_bias),
        .o_valid     (o_ot_valid),
        .o_fmap      (o_ot_fmap)
    );

    // mac channels run in lockstep
    a_acc_valid_agree: assert property (
        @(posedge clk) disable iff (!reset_n)
        (&w_acc_valid) || !(|w_acc_valid)
    ) else $error("accumulator valids disagree");

    // end to end, output 4 cycles after the accepted pixel
    a_core_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> $past(i_in_valid, 4)
    ) else $error("output strobe not 4 cycles after a pixel");

endmodule

// ==== hw/cnn_pkg.sv ====
//==================================================
// layer dimensions, bit widths and data types of the
// streaming conv layer, imported by every RTL module
//==================================================

package cnn_pkg;

    //==================================================
    // layer dimensions
    //==================================================
    // input channels, side by side on the pixel bus
    localparam int CI = 2;
    // output channels, one mac block each
    localparam int CO = 2;
    // square kernel
    localparam int K = 3;

    //==================================================
    // bit widths
    //==================================================
    // signed input pixel
    localparam int IBW = 8;
    // signed weight
    localparam int W_BW = 4;
    // signed bias
    localparam int B_BW = 8;
    // product width plus 5 guard bits for CI*K*K = 18 terms
    localparam int ACC_BW = IBW + W_BW + 5;
    // one more bit for the bias add
    localparam int AB_BW = ACC_BW + 1;
    // relu result, sign bit dropped
    localparam int OBW = AB_BW - 1;

    //==================================================
    // data types
    //==================================================
    // one pixel of one channel
    typedef logic signed [IBW-1:0] pixel_t;
    // one kernel tap
    typedef logic signed [W_BW-1:0] weight_t;
    // per output channel bias
    typedef logic signed [B_BW-1:0] bias_t;
    // window sum of one output channel
    typedef logic signed [ACC_BW-1:0] acc_t;
    // activated output point
    typedef logic [OBW-1:0] ofmap_t;

endpackage

// ==== hw/conv_bias_relu.sv ====
//==================================================
// bias add and relu for all output channels,
// registered on the accumulator strobe
//==================================================
`timescale 1ns/1ns

module conv_bias_relu import cnn_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            i_acc_valid,
    input  acc_t  [CO-1:0]  i_acc,
    input  bias_t [CO-1:0]  i_bias,
    output logic            o_valid,
    output ofmap_t [CO-1:0] o_fmap
);

    //==================================================
    // bias add and clamp
    //==================================================
    logic signed [AB_BW-1:0] add_bias [CO];
    ofmap_t relu [CO];

    always_comb begin
        for (int co = 0; co < CO; co++) begin
            // both operands sign-extended to AB_BW
            add_bias[co] = $signed(i_acc[co]) + $signed(i_bias[co]);
            // negative sum reads zero, else drop the sign bit
            relu[co] = add_bias[co][AB_BW - 1] ? '0 : add_bias[co][OBW-1:0];
        end
    end

    //==================================================
    // output register
    //==================================================
    always_ff @(posedge clk) begin
        if (i_acc_valid) begin
            for (int co = 0; co < CO; co++) begin
                o_fmap[co] <= relu[co];
            end
        end
    end

    // strobe follows the data by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_acc_valid;
        end
    end

endmodule

// ==== hw/conv_param_rom.sv ====
//==================================================
// constant kernel and bias of one output channel,
// picked by CHANNEL_ID, fed to its mac block
//==================================================
`timescale 1ns/1ns

module conv_param_rom import cnn_pkg::*; #(
    parameter int CHANNEL_ID = 0
) (
    output weight_t o_weight [CI][K][K],
    output bias_t   o_bias
);

    //==================================================
    // weights
    //==================================================
    // ((co*7 + ci*5 + ky*3 + kx) mod 9) - 4, range -4..4
    for (genvar ci = 0; ci < CI; ci++) begin : g_ci
        for (genvar ky = 0; ky < K; ky++) begin : g_ky
            for (genvar kx = 0; kx < K; kx++) begin : g_kx
                localparam int WVAL = ((CHANNEL_ID * 7 + ci * 5 + ky * 3 + kx) % 9) - 4;
                assign o_weight[ci][ky][kx] = weight_t'(WVAL);
            end
        end
    end

    //==================================================
    // bias
    //==================================================
    // co*16 - 20
    localparam int BVAL = CHANNEL_ID * 16 - 20;

    assign o_bias = bias_t'(BVAL);

endmodule

// ==== hw/conv_window_gen.sv ====
//==================================================
// row/col counters, per-channel line buffers and the
// KxK window register fed by the raster pixel stream
//==================================================
`timescale 1ns/1ns

module conv_window_gen import cnn_pkg::*; #(
    parameter int IMG_X = 6,
    parameter int IMG_Y = 6
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               i_in_valid,
    input  pixel_t [CI-1:0]    i_in_fmap,
    output logic               o_win_valid,
    output pixel_t             o_window [CI][K][K]
);

    localparam int XW = (IMG_X > 1) ? $clog2(IMG_X) : 1;
    localparam int YW = (IMG_Y > 1) ? $clog2(IMG_Y) : 1;

    //==================================================
    // raster position
    //==================================================
    logic [XW-1:0] col;
    logic [YW-1:0] row;
    // accepted pixel is the bottom-right corner of a window
    logic win_done;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_in_valid) begin
            if (col == XW'(IMG_X - 1)) begin
                col <= '0;
                // wrap at frame end, next frame starts at row 0
                row <= (row == YW'(IMG_Y - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign win_done = i_in_valid && (int'(row) >= K - 1) && (int'(col) >= K - 1);

    //==================================================
    // line buffers
    //==================================================
    // index 0 holds the oldest line, K-1 the youngest
    pixel_t line_buf [CI][K][IMG_X];
    // current column after the vertical shift
    pixel_t col_now [CI][K];

    always_comb begin
        for (int ci = 0; ci < CI; ci++) begin
            // older lines move up by one
            for (int j = 0; j < K - 1; j++) begin
                col_now[ci][j] = line_buf[ci][j + 1][col];
            end
            // new pixel lands in the youngest line
            col_now[ci][K - 1] = i_in_fmap[ci];
        end
    end

    // shift only the column being written
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int ci = 0; ci < CI; ci++) begin
                for (int j = 0; j < K; j++) begin
                    line_buf[ci][j][col] <= col_now[ci][j];
                end
            end
        end
    end

    //==================================================
    // window capture
    //==================================================
    // columns left of col were already shifted this row,
    // the rightmost column comes straight from col_now
    always_ff @(posedge clk) begin
        if (win_done) begin
            for (int ci = 0; ci < CI; ci++) begin
                for (int j = 0; j < K; j++) begin
                    for (int kx = 0; kx < K - 1; kx++) begin
                        o_window[ci][j][kx] <= line_buf[ci][j][int'(col) - (K - 1) + kx];
                    end
                    o_window[ci][j][K - 1] <= col_now[ci][j];
                end
            end
        end
    end

    // one pulse per completed window
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= win_done;
        end
    end

    // window only ever follows an accepted pixel
    a_win_after_pixel: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_win_valid |-> $past(i_in_valid)
    ) else $error("window strobe without an accepted pixel");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the conv layer testbench with Verilator and run it
# pass or fail is read from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f cnn_core.f --top-module cnn_core_tb \
    --Mdir obj_dir -o cnn_core_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cnn_core_sim > sim.log 2>&1

grep -q "TEST OK" sim.log && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }

// ==== verification/cnn_model.svh ====
//==================================================
// reference conv model for the testbench: weight and
// bias rule, frame store, expected output point
//==================================================
`ifndef CNN_MODEL_SVH
`define CNN_MODEL_SVH

// kernel tap, range -4..4
function automatic int model_weight(input int co, input int ci, input int ky, input int kx);
    return ((co * 7 + ci * 5 + ky * 3 + kx) % 9) - 4;
endfunction

// per channel bias
function automatic int model_bias(input int co);
    return co * 16 - 20;
endfunction

// frame being streamed, signed pixel values
int frame [CI][IMG_Y][IMG_X];
// channels clamped by relu since the last clear
int clamp_count;

// expected output for the window whose bottom-right pixel is (y, x)
function automatic logic [CO*OBW-1:0] model_point(input int y, input int x);
    logic [CO*OBW-1:0] point;
    int sum;
    point = '0;
    for (int co = 0; co < CO; co++) begin
        sum = model_bias(co);
        for (int ci = 0; ci < CI; ci++) begin
            for (int ky = 0; ky < K; ky++) begin
                for (int kx = 0; kx < K; kx++) begin
                    sum += frame[ci][y - K + 1 + ky][x - K + 1 + kx]
                           * model_weight(co, ci, ky, kx);
                end
            end
        end
        // relu
        if (sum < 0) begin
            clamp_count++;
            point[co*OBW +: OBW] = '0;
        end else begin
            point[co*OBW +: OBW] = OBW'(sum);
        end
    end
    return point;
endfunction

`endif

// ==== verification/cnn_core_tb.sv ====
//==================================================
// directed testbench of the conv layer top, checks
// every output point and its latency against a model
//==================================================
`timescale 1ns/1ns

module cnn_core_tb import cnn_pkg::*; ();

    //==================================================
    // setup
    //==================================================
    localparam int IMG_X = 6;
    localparam int IMG_Y = 6;
    localparam int SEED = 32'h78c2;
    localparam int DRIVE_DELAY = 10;
    // cycles from valid pixel to output strobe
    localparam int LATENCY = 4;
    localparam int OUTS_PER_FRAME = (IMG_X - K + 1) * (IMG_Y - K + 1);
    // ramp, gapped, relu, two back to back
    localparam int N_FRAMES = 5;
    // worst case 4 cycles per pixel, plus reset, idle and drain
    localparam int TIMEOUT_CYCLES = N_FRAMES * IMG_X * IMG_Y * 4 + 200;

    logic              clk = 1'b0;
    logic              reset_n;
    logic              i_in_valid;
    logic [CI*IBW-1:0] i_in_fmap;
    logic              o_ot_valid;
    logic [CO*OBW-1:0] o_ot_fmap;

    // expected points and the cycle each must show up in
    logic [CO*OBW-1:0] exp_q [$];
    int                cyc_q [$];
    int                cycle = 0;
    int                out_count = 0;
    string             cur_test = "none";

    `include "cnn_model.svh"

    cnn_core #(
        .IMG_X (IMG_X),
        .IMG_Y (IMG_Y)
    ) UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout in %s, outputs never drained", cur_test));
        end
    end

    //==================================================
    // output monitor
    //==================================================
    always @(negedge clk) begin
        logic [CO*OBW-1:0] exp_val;
        int                exp_cyc;
        if (reset_n && o_ot_valid) begin
            assert (exp_q.size() != 0)
            else report_failure($sformatf("unexpected output in %s", cur_test));
            if (exp_q.size() != 0) begin
                exp_val = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                out_count++;
                assert (o_ot_fmap === exp_val)
                else report_failure($sformatf("Error: %s expected %h actual %h",
                                              cur_test, exp_val, o_ot_fmap));
                assert (cycle == exp_cyc)
                else report_failure($sformatf("Error: %s expected cycle %0d actual cycle %0d",
                                              cur_test, exp_cyc, cycle));
            end
        end
    end

    //==================================================
    // drivers
    //==================================================
    // raster order, up to max_gap idle cycles before each pixel
    task automatic drive_frame(input int max_gap);
        int gap;
        for (int y = 0; y < IMG_Y; y++) begin
            for (int x = 0; x < IMG_X; x++) begin
                gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                for (int ci = 0; ci < CI; ci++) begin
                    i_in_fmap[ci*IBW +: IBW] = IBW'(frame[ci][y][x]);
                end
                i_in_valid = 1'b1;
                // completing pixel, queue its point
                if (y >= K - 1 && x >= K - 1) begin
                    exp_q.push_back(model_point(y, x));
                    cyc_q.push_back(cycle + LATENCY);
                end
                @(posedge clk);
                #DRIVE_DELAY;
                i_in_valid = 1'b0;
            end
        end
    endtask

    task automatic fill_random();
        for (int ci = 0; ci < CI; ci++) begin
            for (int y = 0; y < IMG_Y; y++) begin
                for (int x = 0; x < IMG_X; x++) begin
                    frame[ci][y][x] = int'($urandom_range(255, 0)) - 128;
                end
            end
        end
    endtask

    // last point is due LATENCY cycles after the final pixel
    // two spare cycles catch a late or extra strobe
    task automatic drain_and_count(input int start_count, input int expected);
        repeat (LATENCY + 2) @(posedge clk);
        #DRIVE_DELAY;
        assert (out_count - start_count == expected)
        else report_failure($sformatf("Error: %s expected %0d outputs actual %0d",
                                      cur_test, expected, out_count - start_count));
    endtask

    //==================================================
    // tests
    //==================================================
    task automatic test_reset_idle();
        cur_test = "test_reset_idle";
        repeat (20) begin
            @(negedge clk);
            assert (o_ot_valid === 1'b0)
            else report_failure("output strobe seen while idle after reset");
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic test_ramp_frame();
        int start;
        cur_test = "test_ramp_frame";
        start = out_count;
        for (int ci = 0; ci < CI; ci++) begin
            for (int y = 0; y < IMG_Y; y++) begin
                for (int x = 0; x < IMG_X; x++) begin
                    frame[ci][y][x] = (y * IMG_X + x) * 3 - 50 + ci * 7;
                end
            end
        end
        drive_frame(0);
        drain_and_count(start, OUTS_PER_FRAME);
    endtask

    task automatic test_gapped_valid();
        int start;
        cur_test = "test_gapped_valid";
        start = out_count;
        fill_random();
        drive_frame(3);
        drain_and_count(start, OUTS_PER_FRAME);
    endtask

    task automatic test_relu_clamp();
        int start;
        cur_test = "test_relu_clamp";
        start = out_count;
        clamp_count = 0;
        // weights sum to zero, so the flat lower rows leave only the negative bias
        for (int ci = 0; ci < CI; ci++) begin
            for (int y = 0; y < IMG_Y; y++) begin
                for (int x = 0; x < IMG_X; x++) begin
                    frame[ci][y][x] = (y >= 3 || (x + y + ci) % 2 == 0) ? 127 : -128;
                end
            end
        end
        drive_frame(0);
        assert (clamp_count > 0)
        else report_failure("relu stimulus gave no negative sum");
        drain_and_count(start, OUTS_PER_FRAME);
    endtask

    task automatic test_back_to_back();
        int start;
        cur_test = "test_back_to_back";
        start = out_count;
        // frame 1 points are queued before frame 2 overwrites the store
        fill_random();
        drive_frame(0);
        fill_random();
        drive_frame(0);
        drain_and_count(start, 2 * OUTS_PER_FRAME);
    endtask

    //==================================================
    // main sequence
    //==================================================
    initial begin
        void'($urandom(SEED));
        reset_n = 1'b0;
        i_in_valid = 1'b0;
        i_in_fmap = '0;
        clamp_count = 0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        test_reset_idle();
        test_ramp_frame();
        test_gapped_valid();
        test_relu_clamp();
        test_back_to_back();

        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected outputs never arrived", exp_q.size()));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
